//--- all.f
+incdir+include
design/buffer_pkg.sv
design/mover_pkg.sv
design/lsab_in.sv
design/lsab_out.sv
design/block_ram.sv
design/transfer_counter.sv
design/mover_fsm.sv
design/mover_core.sv
sim/mover_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mover_core_tb
result=$(./obj_dir/Vmover_core_tb)
echo "$result"
echo "$result" | grep -qF '*** TEST PASSED ***'

//--- sim/mover_core_tb.sv
`timescale 1ns/1ns
`include "core_params.svh"

module mover_core_tb import buffer_pkg::*, mover_pkg::*;
();

  localparam int NUM_ROWS = 11;
  localparam int ROW_CYCLES = 200;  // Watchdog budget per table row

  typedef struct packed
  {
    sect_t     ch;          // Input channel for fill, output section for empty
    logic [3:0] nwrite;     // Words written on the channel before issue
    dir_e      dir;
    col_addr_t addr;
    count_t    req;
    count_t    exp_sent;
    logic      exp_abrupt;
    logic [5:0] hold;       // Cycles the section is left unread
  } row_t;

  logic                  CLK_n;
  logic                  RST_MASTER;
  logic [`SECTIONS-1:0]  i_wr;
  word_t [`SECTIONS-1:0] i_wr_data;
  logic [`SECTIONS-1:0]  i_rd;
  logic                  i_issue;
  dir_e                  i_dir;
  sect_t                 i_section;
  col_addr_t             i_start_addr;
  count_t                i_count_req;
  logic [`SECTIONS-1:0]  o_in_full;
  word_t [`SECTIONS-1:0] o_rd_data;
  logic [`SECTIONS-1:0]  o_out_empty;
  logic                  o_working;
  logic                  o_done;
  count_t                o_count_sent;
  logic                  o_abrupt_stop;
  logic                  o_irq;

  word_t       mem_model [1 << `MEM_AW];
  word_t       in_q [$];
  logic [15:0] lfsr_state = 16'd26;
  logic        irq_last;
  int          done_cnt = 0;
  int          irq_toggles = 0;
  int          check_cnt = 0;
  int          error_cnt = 0;

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  string names [NUM_ROWS] = '{"fill_rt", "empty_rt", "fill_short", "empty_short",
                              "fill_bp_a", "fill_bp_b", "empty_bp", "zero_fill",
                              "fill_wrap", "empty_wrap", "zero_empty"};

  row_t rows [NUM_ROWS] = '{
    '{2'd0, 4'd6, DIR_FILL,  9'h100, 6'd6,  6'd6,  1'b0, 6'd0},
    '{2'd1, 4'd0, DIR_EMPTY, 9'h100, 6'd6,  6'd6,  1'b0, 6'd0},
    '{2'd3, 4'd3, DIR_FILL,  9'h100, 6'd5,  6'd3,  1'b1, 6'd0},   // Overwrites only 3
    '{2'd2, 4'd0, DIR_EMPTY, 9'h100, 6'd5,  6'd5,  1'b0, 6'd0},
    '{2'd1, 4'd8, DIR_FILL,  9'h040, 6'd8,  6'd8,  1'b0, 6'd0},
    '{2'd2, 4'd4, DIR_FILL,  9'h048, 6'd4,  6'd4,  1'b0, 6'd0},
    '{2'd0, 4'd0, DIR_EMPTY, 9'h040, 6'd12, 6'd12, 1'b0, 6'd20},  // Back-pressure
    '{2'd2, 4'd0, DIR_FILL,  9'h000, 6'd0,  6'd0,  1'b0, 6'd0},
    '{2'd3, 4'd4, DIR_FILL,  9'h1fe, 6'd4,  6'd4,  1'b0, 6'd0},   // Wraps past top
    '{2'd3, 4'd0, DIR_EMPTY, 9'h1fe, 6'd4,  6'd4,  1'b0, 6'd0},
    '{2'd1, 4'd0, DIR_EMPTY, 9'h010, 6'd0,  6'd0,  1'b0, 6'd0}
  };

  mover_core UUT (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
                  .i_wr(i_wr), .i_wr_data(i_wr_data), .i_rd(i_rd),
                  .i_issue(i_issue), .i_dir(i_dir), .i_section(i_section),
                  .i_start_addr(i_start_addr), .i_count_req(i_count_req),
                  .o_in_full(o_in_full), .o_rd_data(o_rd_data),
                  .o_out_empty(o_out_empty), .o_working(o_working), .o_done(o_done),
                  .o_count_sent(o_count_sent), .o_abrupt_stop(o_abrupt_stop),
                  .o_irq(o_irq));

  always #10 CLK_n = ~CLK_n;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual)
    begin
      error_cnt++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_word(output word_t w);
    for (int b = 0; b < `WORD_W; b++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[`WORD_W-2:0], lfsr_state[0]};
    end
  endtask

  task automatic write_words(input sect_t ch, input int n);
    word_t                 w;
    logic [`SECTIONS-1:0]  wr_vec;
    word_t [`SECTIONS-1:0] data_vec;
    for (int i = 0; i < n; i++)
    begin
      next_word(w);
      in_q.push_back(w);
      @(posedge CLK_n);
      wr_vec = '0;
      wr_vec[ch] = 1'b1;
      data_vec = i_wr_data;
      data_vec[ch] = w;
      i_wr      <= wr_vec;
      i_wr_data <= data_vec;
    end
    @(posedge CLK_n);
    i_wr <= '0;
  endtask

  task automatic issue_block(input dir_e dir, input sect_t sect, input col_addr_t addr,
                             input count_t cnt);
    @(posedge CLK_n);
    i_issue      <= 1'b1;
    i_dir        <= dir;
    i_section    <= sect;
    i_start_addr <= addr;
    i_count_req  <= cnt;
    @(posedge CLK_n);
    i_issue <= 1'b0;
  endtask

  task automatic wait_done(input int start_cnt);
    wait (done_cnt != start_cnt);
  endtask

  // Takes the head word, then pops it with a one-cycle read strobe
  task automatic read_word(input sect_t sect, output word_t w);
    logic [`SECTIONS-1:0] rd_vec;
    @(negedge CLK_n);
    while (o_out_empty[sect])
      @(negedge CLK_n);
    w = o_rd_data[sect];
    rd_vec = '0;
    rd_vec[sect] = 1'b1;
    @(posedge CLK_n);
    i_rd <= rd_vec;
    @(posedge CLK_n);
    i_rd <= '0;
  endtask

  task automatic drain_section(input string name, input sect_t sect, input col_addr_t addr,
                               input int n, input int hold, input int start_cnt);
    word_t w;
    if (hold > 0)
    begin
      repeat (hold) @(negedge CLK_n);
      check_value({name, "_stall_working"}, 1, o_working);
      check_value({name, "_stall_done"}, start_cnt, done_cnt);
    end
    for (int i = 0; i < n; i++)
    begin
      read_word(sect, w);
      check_value({name, "_data"}, mem_model[col_addr_t'(addr + i)], w);
    end
  endtask

  // --------------------------------------------------
  // Done and interrupt monitor
  // --------------------------------------------------
  always @(negedge CLK_n)
  begin
    if (!RST_MASTER)
    begin
      if (o_irq != irq_last)
        irq_toggles++;
      if (o_done)
      begin
        check_value("irq_toggle", 1, o_irq ^ irq_last);  // Toggles on the done edge
        done_cnt++;
      end
    end
    irq_last = o_irq;
  end

  initial
  begin
    repeat (ROW_CYCLES * NUM_ROWS) @(posedge CLK_n);
    $display("Watchdog timeout: transfers did not finish within %0d cycles",
             ROW_CYCLES * NUM_ROWS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    row_t row;
    int   start_cnt;
    CLK_n        = 1'b0;
    RST_MASTER   = 1'b1;
    i_wr         = '0;
    i_wr_data    = '0;
    i_rd         = '0;
    i_issue      = 1'b0;
    i_dir        = DIR_FILL;
    i_section    = '0;
    i_start_addr = '0;
    i_count_req  = '0;
    repeat (2) @(posedge CLK_n);
    RST_MASTER <= 1'b0;

    @(negedge CLK_n);
    check_value("reset_working", 0, o_working);
    check_value("reset_done", 0, o_done);
    check_value("reset_abrupt", 0, o_abrupt_stop);
    check_value("reset_irq", 0, o_irq);
    check_value("reset_out_empty", 4'hf, o_out_empty);
    check_value("reset_in_full", 0, o_in_full);
    check_value("reset_count_sent", 0, o_count_sent);

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      row = rows[r];
      in_q.delete();
      write_words(row.ch, int'(row.nwrite));
      @(negedge CLK_n);
      check_value({names[r], "_in_full"},
                  (row.nwrite == `SECT_DEPTH) ? (32'd1 << row.ch) : 32'd0, o_in_full);
      start_cnt = done_cnt;
      issue_block(row.dir, row.ch, row.addr, row.req);
      @(negedge CLK_n);
      check_value({names[r], "_working"}, row.req != '0, o_working);
      if (row.dir == DIR_EMPTY)
        fork
          wait_done(start_cnt);
          drain_section(names[r], row.ch, row.addr, int'(row.exp_sent), int'(row.hold),
                        start_cnt);
        join
      else
        wait_done(start_cnt);
      check_value({names[r], "_sent"}, row.exp_sent, o_count_sent);
      check_value({names[r], "_abrupt"}, row.exp_abrupt, o_abrupt_stop);
      check_value({names[r], "_irq_count"}, r + 1, irq_toggles);
      if (row.dir == DIR_FILL)
        for (int i = 0; i < int'(row.exp_sent); i++)
          mem_model[col_addr_t'(row.addr + i)] = in_q.pop_front();
    end

    // No stray words left in any section
    @(negedge CLK_n);
    check_value("final_out_empty", 4'hf, o_out_empty);
    check_value("final_in_full", 0, o_in_full);
    check_value("done_count", NUM_ROWS, done_cnt);
    check_value("irq_count", NUM_ROWS, irq_toggles);

    $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- design/mover_core.sv
`timescale 1ns/1ns
`include "core_params.svh"

module mover_core import buffer_pkg::*, mover_pkg::*;
(
  input  logic                  CLK_n,
  input  logic                  RST_MASTER,
  input  logic [`SECTIONS-1:0]  i_wr,
  input  word_t [`SECTIONS-1:0] i_wr_data,
  input  logic [`SECTIONS-1:0]  i_rd,
  input  logic                  i_issue,
  input  dir_e                  i_dir,
  input  sect_t                 i_section,
  input  col_addr_t             i_start_addr,
  input  count_t                i_count_req,
  output logic [`SECTIONS-1:0]  o_in_full,
  output word_t [`SECTIONS-1:0] o_rd_data,
  output logic [`SECTIONS-1:0]  o_out_empty,
  output logic                  o_working,
  output logic                  o_done,
  output count_t                o_count_sent,
  output logic                  o_abrupt_stop,
  output logic                  o_irq
);

  word_t                head_w;
  word_t                rdata_w;
  logic [`SECTIONS-1:0] in_empty_w;
  logic [`SECTIONS-1:0] out_room_w;
  col_addr_t            addr_w;
  sect_t                sel_w;
  logic                 load_w;
  logic                 step_w;
  logic                 last_w;
  logic                 pop_w;
  logic                 push_w;
  logic                 mem_we_w;
  logic                 mem_re_w;

  // --------------------------------------------------
  // Channel buffers
  // --------------------------------------------------
  lsab_in u_lsab_in (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
                     .i_wr(i_wr), .i_wr_data(i_wr_data),
                     .i_sel(sel_w), .i_pop(pop_w),
                     .o_head(head_w), .o_empty(in_empty_w), .o_full(o_in_full));

  lsab_out u_lsab_out (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
                       .i_push(push_w), .i_sel(sel_w), .i_push_data(rdata_w),
                       .i_rd(i_rd), .o_rd_data(o_rd_data),
                       .o_empty(o_out_empty), .o_room(out_room_w));

  // --------------------------------------------------
  // Block memory and mover engine
  // --------------------------------------------------
  block_ram u_block_ram (.CLK_n(CLK_n),
                         .i_we(mem_we_w), .i_waddr(addr_w), .i_wdata(head_w),
                         .i_re(mem_re_w), .i_raddr(addr_w), .o_rdata(rdata_w));

  transfer_counter u_transfer_counter (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
                                       .i_load(load_w), .i_start(i_start_addr),
                                       .i_count_req(i_count_req), .i_step(step_w),
                                       .o_addr(addr_w), .o_count_sent(o_count_sent),
                                       .o_last(last_w));

  mover_fsm u_mover_fsm (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
                         .i_issue(i_issue), .i_dir(i_dir), .i_section(i_section),
                         .i_in_empty(in_empty_w), .i_out_room(out_room_w),
                         .i_last(last_w),
                         .o_load(load_w), .o_step(step_w), .o_pop(pop_w),
                         .o_mem_we(mem_we_w), .o_mem_re(mem_re_w), .o_push(push_w),
                         .o_sel(sel_w), .o_working(o_working), .o_done(o_done),
                         .o_abrupt_stop(o_abrupt_stop), .o_irq(o_irq));

endmodule

//--- design/mover_fsm.sv
`timescale 1ns/1ns
`include "core_params.svh"

module mover_fsm import buffer_pkg::*, mover_pkg::*;
(
  input  logic                  CLK_n,
  input  logic                  RST_MASTER,
  input  logic                  i_issue,
  input  dir_e                  i_dir,
  input  sect_t                 i_section,
  input  logic [`SECTIONS-1:0]  i_in_empty,
  input  logic [`SECTIONS-1:0]  i_out_room,
  input  logic                  i_last,
  output logic                  o_load,
  output logic                  o_step,
  output logic                  o_pop,
  output logic                  o_mem_we,
  output logic                  o_mem_re,
  output logic                  o_push,
  output sect_t                 o_sel,
  output logic                  o_working,
  output logic                  o_done,
  output logic                  o_abrupt_stop,
  output logic                  o_irq
);

  mover_state_e state;
  mover_state_e state_nxt;
  sect_t        sel_q;
  logic         stop_nxt;

  // --------------------------------------------------
  // Next state and beat strobes
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    o_load    = 1'b0;
    o_step    = 1'b0;
    o_pop     = 1'b0;
    o_mem_we  = 1'b0;
    o_mem_re  = 1'b0;
    stop_nxt  = 1'b0;
    case (state)
      IDLE:
        if (i_issue)
        begin
          o_load = 1'b1;
          if (i_last)
            state_nxt = DONE;  // Count zero
          else if (i_dir == DIR_FILL)
            state_nxt = FILL;
          else
            state_nxt = EMPTY;
        end
      FILL:
        if (i_in_empty[sel_q])
        begin
          stop_nxt  = 1'b1;  // Ran out of input words
          state_nxt = DONE;
        end
        else
        begin
          o_pop    = 1'b1;
          o_mem_we = 1'b1;
          o_step   = 1'b1;
          if (i_last)
            state_nxt = DONE;
        end
      EMPTY:
        if (i_out_room[sel_q])  // Otherwise stall on the same address
        begin
          o_mem_re = 1'b1;
          o_step   = 1'b1;
          if (i_last)
            state_nxt = DONE;
        end
      DONE:
        state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  // --------------------------------------------------
  // State, section latch and status registers
  // --------------------------------------------------
  always_ff @(posedge CLK_n)
    if (RST_MASTER)
    begin
      state         <= IDLE;
      sel_q         <= '0;
      o_push        <= 1'b0;
      o_abrupt_stop <= 1'b0;
      o_irq         <= 1'b0;
    end
    else
    begin
      state  <= state_nxt;
      o_push <= o_mem_re;  // Read data lands one cycle later
      if (o_load)
      begin
        sel_q         <= i_section;
        o_abrupt_stop <= 1'b0;
      end
      else if (stop_nxt)
        o_abrupt_stop <= 1'b1;
      if (state_nxt == DONE)
        o_irq <= ~o_irq;  // One toggle per block
    end

  assign o_sel     = sel_q;
  assign o_working = (state == FILL) || (state == EMPTY);
  assign o_done    = (state == DONE);

  a_done_pulse: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    o_done |=> !o_done)
    else $error("o_done held longer than one cycle");

  // Fill and empty beats never overlap
  a_pop_push: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    !(o_pop && o_push))
    else $error("pop and push in the same cycle");

endmodule

//--- design/transfer_counter.sv
`timescale 1ns/1ns
`include "core_params.svh"

module transfer_counter import buffer_pkg::*;
(
  input  logic       CLK_n,
  input  logic       RST_MASTER,
  input  logic       i_load,
  input  col_addr_t  i_start,
  input  count_t     i_count_req,
  input  logic       i_step,
  output col_addr_t  o_addr,
  output count_t     o_count_sent,
  output logic       o_last
);

  count_t count_req_q;

  // --------------------------------------------------
  // Address and count registers
  // --------------------------------------------------
  always_ff @(posedge CLK_n)
    if (RST_MASTER)
    begin
      o_addr       <= '0;
      o_count_sent <= '0;
      count_req_q  <= '0;
    end
    else if (i_load)
    begin
      o_addr       <= i_start;
      o_count_sent <= '0;
      count_req_q  <= i_count_req;
    end
    else if (i_step)
    begin
      o_addr       <= o_addr + col_addr_t'(1);  // Wraps at memory size
      o_count_sent <= o_count_sent + count_t'(1);
    end

  // Zero request ends the block right at load
  assign o_last = i_load ? (i_count_req == '0)
                         : (count_t'(o_count_sent + count_t'(1)) == count_req_q);

endmodule

//--- design/block_ram.sv
`timescale 1ns/1ns
`include "core_params.svh"

module block_ram
(
  input  logic                CLK_n,
  input  logic                i_we,
  input  logic [`MEM_AW-1:0]  i_waddr,
  input  logic [`WORD_W-1:0]  i_wdata,
  input  logic                i_re,
  input  logic [`MEM_AW-1:0]  i_raddr,
  output logic [`WORD_W-1:0]  o_rdata
);

  localparam int DEPTH = 1 << `MEM_AW;

  logic [`WORD_W-1:0] mem [DEPTH];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  always_ff @(posedge CLK_n)
    if (i_we)
      mem[i_waddr] <= i_wdata;

  // --------------------------------------------------
  // Registered read port
  // --------------------------------------------------
  always_ff @(posedge CLK_n)
    if (i_re)
      o_rdata <= mem[i_raddr];  // Valid one cycle after i_re

endmodule

//--- design/lsab_out.sv
`timescale 1ns/1ns
`include "core_params.svh"

module lsab_out import buffer_pkg::*;
(
  input  logic                         CLK_n,
  input  logic                         RST_MASTER,
  input  logic                         i_push,
  input  sect_t                        i_sel,
  input  word_t                        i_push_data,
  input  logic [`SECTIONS-1:0]         i_rd,
  output word_t [`SECTIONS-1:0]        o_rd_data,
  output logic [`SECTIONS-1:0]         o_empty,
  output logic [`SECTIONS-1:0]         o_room
);

  localparam int PW = $clog2(`SECT_DEPTH);
  localparam logic [PW:0] FULL_CNT = `SECT_DEPTH;
  localparam logic [PW:0] ROOM_MAX = `SECT_DEPTH - 2;

  logic [`SECTIONS-1:0] full;

  // --------------------------------------------------
  // One circular section per channel
  // --------------------------------------------------
  for (genvar s = 0; s < `SECTIONS; s++)
  begin : g_sect
    word_t         mem [`SECT_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   fill;
    logic          do_push;
    logic          do_rd;

    assign do_push = i_push && (i_sel == sect_t'(s)) && !full[s];
    assign do_rd   = i_rd[s] && !o_empty[s];  // Read of empty ignored

    always_ff @(posedge CLK_n)
      if (do_push)
        mem[wr_ptr] <= i_push_data;

    always_ff @(posedge CLK_n)
      if (RST_MASTER)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill   <= '0;
      end
      else
      begin
        if (do_push)
          wr_ptr <= wr_ptr + 1'b1;
        if (do_rd)
          rd_ptr <= rd_ptr + 1'b1;
        if (do_push && !do_rd)
          fill <= fill + 1'b1;
        else if (do_rd && !do_push)
          fill <= fill - 1'b1;
      end

    assign o_rd_data[s] = mem[rd_ptr];
    assign o_empty[s]   = (fill == '0);
    assign full[s]      = (fill == FULL_CNT);
    assign o_room[s]    = (fill <= ROOM_MAX);  // Space for in-flight word plus one
  end

  // Room flag must cover the read still in flight
  a_push_not_full: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    i_push |-> !full[i_sel])
    else $error("lsab_out push into full section %0d", i_sel);

endmodule

//--- design/lsab_in.sv
`timescale 1ns/1ns
`include "core_params.svh"

module lsab_in import buffer_pkg::*;
(
  input  logic                         CLK_n,
  input  logic                         RST_MASTER,
  input  logic [`SECTIONS-1:0]         i_wr,
  input  word_t [`SECTIONS-1:0]        i_wr_data,
  input  sect_t                        i_sel,
  input  logic                         i_pop,
  output word_t                        o_head,
  output logic [`SECTIONS-1:0]         o_empty,
  output logic [`SECTIONS-1:0]         o_full
);

  localparam int PW = $clog2(`SECT_DEPTH);
  localparam logic [PW:0] FULL_CNT = `SECT_DEPTH;

  word_t heads [`SECTIONS];

  // --------------------------------------------------
  // One circular section per channel
  // --------------------------------------------------
  for (genvar s = 0; s < `SECTIONS; s++)
  begin : g_sect
    word_t         mem [`SECT_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   fill;
    logic          do_wr;
    logic          do_pop;

    assign do_wr  = i_wr[s] && !o_full[s];  // Word dropped when full
    assign do_pop = i_pop && (i_sel == sect_t'(s)) && !o_empty[s];

    always_ff @(posedge CLK_n)
      if (do_wr)
        mem[wr_ptr] <= i_wr_data[s];

    always_ff @(posedge CLK_n)
      if (RST_MASTER)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill   <= '0;
      end
      else
      begin
        if (do_wr)
          wr_ptr <= wr_ptr + 1'b1;
        if (do_pop)
          rd_ptr <= rd_ptr + 1'b1;
        if (do_wr && !do_pop)
          fill <= fill + 1'b1;
        else if (do_pop && !do_wr)
          fill <= fill - 1'b1;
      end

    assign heads[s]   = mem[rd_ptr];
    assign o_empty[s] = (fill == '0);
    assign o_full[s]  = (fill == FULL_CNT);
  end

  assign o_head = heads[i_sel];  // Head of the mover's section

  // Mover only pops when it has seen a word waiting
  a_pop_not_empty: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    i_pop |-> !o_empty[i_sel])
    else $error("lsab_in pop of empty section %0d", i_sel);

endmodule

//--- design/mover_pkg.sv
package mover_pkg;

  // Direction opcode of a block transfer
  typedef enum logic
  {
    DIR_FILL,  // Input section to memory
    DIR_EMPTY  // Memory to output section
  } dir_e;

  // Mover sequencer states
  typedef enum logic [1:0]
  {
    IDLE,
    FILL,
    EMPTY,
    DONE
  } mover_state_e;

endpackage

//--- design/buffer_pkg.sv
`include "core_params.svh"

package buffer_pkg;

  // One data word as moved through the buffers
  typedef logic [`WORD_W-1:0] word_t;

  // Channel and section index
  typedef logic [1:0] sect_t;

  // Column address into the block memory
  typedef logic [`MEM_AW-1:0] col_addr_t;

  // Requested and sent word counts
  typedef logic [`COUNT_W-1:0] count_t;

endpackage

//--- include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// --------------------------------------------------
// Data path sizes
// --------------------------------------------------
`define WORD_W 32     // Bits per data word
`define SECTIONS 4    // One section per device channel
`define SECT_DEPTH 8  // Words per buffer section

// --------------------------------------------------
// Block memory and transfer sizes
// --------------------------------------------------
`define MEM_AW 9      // 512 word columns
`define COUNT_W 6     // Requested and sent counts

`endif
